/* src/mipsPkg.sv */
/* Shared types for the memory and write-back end of the integer pipeline.
   Memory depth is not defined here; it is a parameter of the top level. */
`default_nettype none

package mipsPkg;

    // data word, used for memory contents, ALU results and registers.
    typedef logic [31:0] word_t;

    // byte address as produced by the execute stage.
    typedef logic [31:0] addr_t;

    // general register number.
    typedef logic [4:0] regAddr_t;

    // one bit per byte lane of a word, lane 0 is bits 7:0.
    typedef logic [3:0] byteEnable_t;

    // operation that travels down the pipeline with each instruction.
    typedef enum logic [3:0] {
        OP_NONE,
        OP_ALU,
        OP_LW,
        OP_LH,
        OP_LHU,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_SH,
        OP_SB
    } memOp_t;

    // lane masks for an access at offset zero, shifted up by the offset.
    localparam byteEnable_t BE_WORD = 4'b1111;
    localparam byteEnable_t BE_HALF = 4'b0011;
    localparam byteEnable_t BE_BYTE = 4'b0001;

    // register 0 is hardwired to zero and never written.
    localparam regAddr_t ZERO_REG = 5'd0;

    function automatic logic isLoad(input memOp_t op);
        case (op)
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic logic isStore(input memOp_t op);
        case (op)
            OP_SW, OP_SH, OP_SB:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/memStage.sv */
/* Data memory of the pipeline. MEM_WORDS must be a power of two; address bits
   above the array and below the access unit are ignored, so misaligned or
   out-of-range accesses alias silently. Contents start at zero, no reset. */
`timescale 1ns/1ps
`default_nettype none

module memStage
    import mipsPkg::*;
#(
    parameter int MEM_WORDS = 256
)
(
    input  wire logic   clk,
    input  wire logic   valid,
    input  wire memOp_t op,
    input  wire addr_t  address,
    input  wire word_t  storeData,
    output word_t       memWord
);

    localparam int INDEX_BITS = $clog2(MEM_WORDS);

    word_t memory [MEM_WORDS];

    logic [INDEX_BITS-1:0] wordIndex;
    logic [1:0] offset;
    byteEnable_t byteEnable;
    word_t laneData;
    logic storeValid;

    // zero the array once at time zero.
    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            memory[i] = '0;
        end
    end

    // word index sits right above the two byte offset bits.
    assign wordIndex = address[INDEX_BITS+1:2];
    assign offset    = address[1:0];

    // loads read the whole word; extraction happens in write-back.
    assign memWord = memory[wordIndex];

    assign storeValid = valid && isStore(op);

    // lane mask and replicated store data for the access size.
    always_comb
    begin
        byteEnable = '0;
        laneData   = storeData;
        case (op)
            OP_SW:
            begin
                byteEnable = BE_WORD;
                laneData   = storeData;
            end
            OP_SH:
            begin
                // halfword uses only offset bit 1.
                byteEnable = BE_HALF << {offset[1], 1'b0};
                laneData   = {2{storeData[15:0]}};
            end
            OP_SB:
            begin
                byteEnable = BE_BYTE << offset;
                laneData   = {4{storeData[7:0]}};
            end
            default:
            begin
                byteEnable = '0;
            end
        endcase
    end

    // only the enabled lanes of the addressed word change.
    always_ff @(posedge clk)
    begin
        if (storeValid)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (byteEnable[lane])
                begin
                    memory[wordIndex][lane*8 +: 8] <= laneData[lane*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/memWbRegister.sv */
/* MEM/WB pipeline register. It loads every cycle with no stall input;
   only the valid flag is reset, the payload is don't-care while it is low. */
`timescale 1ns/1ps
`default_nettype none

module memWbRegister
    import mipsPkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       valid,
    input  wire memOp_t     op,
    input  wire logic [1:0] offset,
    input  wire word_t      memWord,
    input  wire word_t      aluResult,
    input  wire regAddr_t   destReg,
    input  wire addr_t      pc,
    output logic            validWb,
    output memOp_t          opWb,
    output logic [1:0]      offsetWb,
    output word_t           memWordWb,
    output word_t           aluResultWb,
    output regAddr_t        destRegWb,
    output addr_t           pcWb
);

    // control state; a bubble in memory stage becomes a bubble here.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            validWb <= 1'b0;
        end
        else
        begin
            validWb <= valid;
        end
    end

    // write-back payload of the instruction leaving the memory stage.
    always_ff @(posedge clk)
    begin
        opWb        <= op;
        offsetWb    <= offset;
        memWordWb   <= memWord;
        aluResultWb <= aluResult;
        destRegWb   <= destReg;
        pcWb        <= pc;
    end

endmodule

`default_nettype wire

/* src/writeBackStage.sv */
/* Write-back stage: load extraction, extension and result select.
   Stores and OP_NONE never request a register write. */
`timescale 1ns/1ps
`default_nettype none

module writeBackStage
    import mipsPkg::*;
(
    input  wire logic       validWb,
    input  wire memOp_t     opWb,
    input  wire logic [1:0] offsetWb,
    input  wire word_t      memWordWb,
    input  wire word_t      aluResultWb,
    input  wire regAddr_t   destRegWb,
    output logic            regWriteEnable,
    output regAddr_t        regWriteAddr,
    output word_t           regWriteData
);

    logic [15:0] loadHalf;
    logic [7:0]  loadByte;
    word_t       loadData;
    logic        writesRegister;

    // halfword picked by offset bit 1, byte by the full offset.
    assign loadHalf = offsetWb[1] ? memWordWb[31:16] : memWordWb[15:0];
    assign loadByte = memWordWb[offsetWb*8 +: 8];

    // extend the selected unit to a full word.
    always_comb
    begin
        case (opWb)
            OP_LW:
            begin
                loadData = memWordWb;
            end
            OP_LH:
            begin
                loadData = {{16{loadHalf[15]}}, loadHalf};
            end
            OP_LHU:
            begin
                loadData = {16'b0, loadHalf};
            end
            OP_LB:
            begin
                loadData = {{24{loadByte[7]}}, loadByte};
            end
            OP_LBU:
            begin
                loadData = {24'b0, loadByte};
            end
            default:
            begin
                // not a load, the value is not selected below.
                loadData = memWordWb;
            end
        endcase
    end

    assign writesRegister = isLoad(opWb) || (opWb == OP_ALU);

    // a write to register 0 is dropped here, before the register file.
    assign regWriteEnable = validWb && writesRegister && (destRegWb != ZERO_REG);
    assign regWriteAddr   = destRegWb;
    assign regWriteData   = isLoad(opWb) ? loadData : aluResultWb;

endmodule

`default_nettype wire

/* src/registerFile.sv */
/* General register file, 32 entries, two combinational read ports.
   No write-through: a read sees a new value only after the write edge.
   Register 0 has no storage and always reads zero. */
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import mipsPkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     regWriteEnable,
    input  wire regAddr_t regWriteAddr,
    input  wire word_t    regWriteData,
    input  wire regAddr_t rsAddr,
    input  wire regAddr_t rtAddr,
    output word_t         rsData,
    output word_t         rtData
);

    // storage for registers 1 to 31 only.
    word_t registers [1:31];

    // read view of all 32 entries with entry 0 tied to zero.
    word_t readView [32];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < 32; i++)
            begin
                registers[i] <= '0;
            end
        end
        else
        begin
            // the decode loop has no slot for address 0.
            for (int i = 1; i < 32; i++)
            begin
                if (regWriteEnable && (regWriteAddr == regAddr_t'(i)))
                begin
                    registers[i] <= regWriteData;
                end
            end
        end
    end

    always_comb
    begin
        readView[0] = '0;
        for (int i = 1; i < 32; i++)
        begin
            readView[i] = registers[i];
        end
    end

    assign rsData = readView[rsAddr];
    assign rtData = readView[rtAddr];

endmodule

`default_nettype wire

/* src/memWbTop.sv */
/* Memory and write-back end of the pipeline, one instruction per cycle.
   No handshake or stall; valid low issues a bubble. */
`timescale 1ns/1ps
`default_nettype none

module memWbTop
    import mipsPkg::*;
#(
    parameter int MEM_WORDS = 256
)
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     valid,
    input  wire memOp_t   op,
    input  wire addr_t    address,
    input  wire word_t    storeData,
    input  wire word_t    aluResult,
    input  wire regAddr_t destReg,
    input  wire addr_t    pc,
    input  wire regAddr_t rsAddr,
    input  wire regAddr_t rtAddr,
    output wire word_t    rsData,
    output wire word_t    rtData,
    output wire logic     regWriteEnable,
    output wire regAddr_t regWriteAddr,
    output wire word_t    regWriteData,
    output wire addr_t    pcWb
);

    word_t      memWord;
    logic       validWb;
    memOp_t     opWb;
    logic [1:0] offsetWb;
    word_t      memWordWb;
    word_t      aluResultWb;
    regAddr_t   destRegWb;

    memStage #(
        .MEM_WORDS(MEM_WORDS)
    ) memStage_i (
        .clk       (clk),
        .valid     (valid),
        .op        (op),
        .address   (address),
        .storeData (storeData),
        .memWord   (memWord)
    );

    // byte offset travels on so write-back can pick the lane.
    memWbRegister memWbRegister_i (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .op          (op),
        .offset      (address[1:0]),
        .memWord     (memWord),
        .aluResult   (aluResult),
        .destReg     (destReg),
        .pc          (pc),
        .validWb     (validWb),
        .opWb        (opWb),
        .offsetWb    (offsetWb),
        .memWordWb   (memWordWb),
        .aluResultWb (aluResultWb),
        .destRegWb   (destRegWb),
        .pcWb        (pcWb)
    );

    writeBackStage writeBackStage_i (
        .validWb        (validWb),
        .opWb           (opWb),
        .offsetWb       (offsetWb),
        .memWordWb      (memWordWb),
        .aluResultWb    (aluResultWb),
        .destRegWb      (destRegWb),
        .regWriteEnable (regWriteEnable),
        .regWriteAddr   (regWriteAddr),
        .regWriteData   (regWriteData)
    );

    registerFile registerFile_i (
        .clk            (clk),
        .reset          (reset),
        .regWriteEnable (regWriteEnable),
        .regWriteAddr   (regWriteAddr),
        .regWriteData   (regWriteData),
        .rsAddr         (rsAddr),
        .rtAddr         (rtAddr),
        .rsData         (rsData),
        .rtData         (rtData)
    );

endmodule

`default_nettype wire

/* test/memWbTb_sva.sv */
/* Assertions on the write-back request and read port 0. Bound into
   registerFile, where the write request, reset and read ports meet. */
`timescale 1ns/1ps
`default_nettype none

module memWbTb_sva
    import mipsPkg::*;
(
    input wire logic     clk,
    input wire logic     reset,
    input wire logic     regWriteEnable,
    input wire regAddr_t regWriteAddr,
    input wire regAddr_t rsAddr,
    input wire word_t    rsData
);

    // register 0 is never a write target.
    property noZeroWrite;
        @(posedge clk) disable iff (reset)
            !(regWriteEnable && (regWriteAddr == ZERO_REG));
    endproperty

    // read port for register 0 returns zero.
    property zeroReadsZero;
        @(posedge clk) (rsAddr == ZERO_REG) |-> (rsData == '0);
    endproperty

    // a reset edge leaves no write-back pending.
    property resetClearsWrite;
        @(posedge clk) reset |=> !regWriteEnable;
    endproperty

    noZeroWriteCheck: assert property (noZeroWrite)
        else $error("write enable raised for register 0");

    zeroReadsZeroCheck: assert property (zeroReadsZero)
        else $error("register 0 read back a nonzero value");

    resetClearsWriteCheck: assert property (resetClearsWrite)
        else $error("write enable high after a reset edge");

endmodule

`default_nettype wire

/* test/memWbTb.sv */
/* Table-driven testbench for the MEM/WB end of the pipeline. Reference memory
   and register models predict the write-back trace and the read ports. The run
   stops at the first mismatch. */
`timescale 1ns/1ps
`default_nettype none

module memWbTb
    import mipsPkg::*;
();

    localparam int MEM_WORDS    = 256;
    localparam int CLOCK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;

    // where an entry's store data or ALU result comes from.
    typedef enum logic [1:0] {
        DATA_FIXED,
        DATA_LFSR,
        DATA_NEG,
        DATA_POS
    } dataMode_t;

    typedef struct {
        logic      valid;
        memOp_t    op;
        addr_t     address;
        regAddr_t  destReg;
        dataMode_t mode;
        word_t     fixedData;
    } stimulus_t;

    logic     clk;
    logic     reset;
    logic     valid;
    memOp_t   op;
    addr_t    address;
    word_t    storeData;
    word_t    aluResult;
    regAddr_t destReg;
    addr_t    pc;
    regAddr_t rsAddr;
    regAddr_t rtAddr;
    word_t    rsData;
    word_t    rtData;
    logic     regWriteEnable;
    regAddr_t regWriteAddr;
    word_t    regWriteData;
    addr_t    pcWb;

    stimulus_t   stimulusTable[$];
    word_t       refMem [MEM_WORDS];
    word_t       refRegs [32];
    logic [31:0] lfsr = 32'hf266;
    int          cycleCount;
    int          cycleLimit;

    // expected trace of the instruction now in write-back.
    logic     expValid;
    logic     expEnable;
    regAddr_t expAddr;
    word_t    expData;
    addr_t    expPc;

    // write that lands in the register file at the coming edge.
    logic     pendingWrite;
    regAddr_t pendingAddr;
    word_t    pendingData;

    memWbTop #(
        .MEM_WORDS(MEM_WORDS)
    ) dut_i (
        .clk            (clk),
        .reset          (reset),
        .valid          (valid),
        .op             (op),
        .address        (address),
        .storeData      (storeData),
        .aluResult      (aluResult),
        .destReg        (destReg),
        .pc             (pc),
        .rsAddr         (rsAddr),
        .rtAddr         (rtAddr),
        .rsData         (rsData),
        .rtData         (rtData),
        .regWriteEnable (regWriteEnable),
        .regWriteAddr   (regWriteAddr),
        .regWriteData   (regWriteData),
        .pcWb           (pcWb)
    );

    bind registerFile memWbTb_sva registerChecks_i (
        .clk            (clk),
        .reset          (reset),
        .regWriteEnable (regWriteEnable),
        .regWriteAddr   (regWriteAddr),
        .rsAddr         (rsAddr),
        .rsData         (rsData)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLOCK_PERIOD / 2) clk = ~clk;
        end
    end

    // taps 32, 22, 2, 1.
    function automatic logic nextBit();
        logic feedback;
        feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], feedback};
        return feedback;
    endfunction

    function automatic word_t randomWord();
        word_t value;
        value = '0;
        for (int i = 0; i < 32; i++)
        begin
            value = {value[30:0], nextBit()};
        end
        return value;
    endfunction

    // a misaligned access drops the address bits below its unit.
    function automatic word_t expectedLoad(input memOp_t loadOp, input word_t word,
                                           input logic [1:0] offset);
        word_t       shifted;
        logic [15:0] half;
        logic [7:0]  unit;
        shifted = word >> (offset[1] ? 16 : 0);
        half = shifted[15:0];
        shifted = word >> (8 * offset);
        unit = shifted[7:0];
        case (loadOp)
            OP_LH:  return word_t'($signed(half));
            OP_LHU: return word_t'(half);
            OP_LB:  return word_t'($signed(unit));
            OP_LBU: return word_t'(unit);
            default: return word;
        endcase
    endfunction

    function automatic word_t mergeStore(input memOp_t storeOp, input word_t word,
                                         input word_t data, input logic [1:0] offset);
        word_t merged;
        merged = word;
        case (storeOp)
            OP_SW:
            begin
                merged = data;
            end
            OP_SH:
            begin
                if (offset[1])
                    merged[31:16] = data[15:0];
                else
                    merged[15:0] = data[15:0];
            end
            OP_SB:
            begin
                merged[8 * offset +: 8] = data[7:0];
            end
            default:
            begin
                merged = word;
            end
        endcase
        return merged;
    endfunction

    task automatic endInFailure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            endInFailure();
        end
    endtask

    task automatic checkRegAddr(input regAddr_t actual, input regAddr_t expected,
                                input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            endInFailure();
        end
    endtask

    task automatic checkEnable(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            endInFailure();
        end
    endtask

    task automatic addEntry(input logic v, input memOp_t o, input addr_t a, input regAddr_t d,
                            input dataMode_t m, input word_t f);
        stimulus_t entry;
        entry.valid     = v;
        entry.op        = o;
        entry.address   = a;
        entry.destReg   = d;
        entry.mode      = m;
        entry.fixedData = f;
        stimulusTable.push_back(entry);
    endtask

    task automatic buildTable();
        dataMode_t signMode;
        memOp_t    loadOp;
        // ALU results and their read-back.
        addEntry(1'b1, OP_ALU, '0, 5'd1, DATA_FIXED, 32'h1234_5678);
        addEntry(1'b1, OP_ALU, '0, 5'd2, DATA_LFSR, '0);
        // load right behind a store to the same word.
        addEntry(1'b1, OP_SW, 32'h10, 5'd0, DATA_LFSR, '0);
        addEntry(1'b1, OP_LW, 32'h10, 5'd3, DATA_FIXED, '0);
        // halfword and byte lanes merged into known words.
        addEntry(1'b1, OP_SW, 32'h20, 5'd0, DATA_FIXED, 32'ha5a5_5a5a);
        for (int off = 0; off < 4; off++)
        begin
            addEntry(1'b1, OP_SH, addr_t'(32'h20 + off), 5'd0, DATA_LFSR, '0);
            addEntry(1'b1, OP_LW, 32'h20, 5'd4, DATA_FIXED, '0);
            addEntry(1'b1, OP_SB, addr_t'(32'h24 + off), 5'd0, DATA_LFSR, '0);
            addEntry(1'b1, OP_LW, 32'h24, 5'd5, DATA_FIXED, '0);
        end
        // extension with the top bit of every byte set, then clear.
        for (int k = 0; k < 2; k++)
        begin
            if (k == 0)
                signMode = DATA_NEG;
            else
                signMode = DATA_POS;
            addEntry(1'b1, OP_SW, 32'h30, 5'd0, signMode, '0);
            for (int off = 0; off < 4; off++)
            begin
                addEntry(1'b1, OP_LB, addr_t'(32'h30 + off), regAddr_t'(13 + off), DATA_FIXED, '0);
                addEntry(1'b1, OP_LBU, addr_t'(32'h30 + off), regAddr_t'(17 + off), DATA_FIXED, '0);
                addEntry(1'b1, OP_LH, addr_t'(32'h30 + off), regAddr_t'(21 + off), DATA_FIXED, '0);
                addEntry(1'b1, OP_LHU, addr_t'(32'h30 + off), regAddr_t'(25 + off), DATA_FIXED, '0);
            end
        end
        // register 0 targets and bubbles.
        addEntry(1'b1, OP_ALU, '0, 5'd0, DATA_FIXED, 32'hffff_ffff);
        addEntry(1'b1, OP_LW, 32'h20, 5'd0, DATA_FIXED, '0);
        addEntry(1'b1, OP_NONE, '0, 5'd6, DATA_FIXED, 32'h0000_0666);
        addEntry(1'b0, OP_ALU, '0, 5'd7, DATA_FIXED, 32'h0bad_0bad);
        addEntry(1'b0, OP_SW, 32'h20, 5'd0, DATA_FIXED, '0);
        addEntry(1'b1, OP_LW, 32'h20, 5'd8, DATA_FIXED, '0);
        // loads and ALU ops every cycle on a few reused registers.
        for (int k = 0; k < 12; k++)
        begin
            if (k % 4 == 0)
                loadOp = OP_LW;
            else
                loadOp = OP_LHU;
            if (k % 2 == 0)
                addEntry(1'b1, loadOp, addr_t'(32'h20 + 4 * (k % 3)), regAddr_t'(9 + k % 4),
                         DATA_FIXED, '0);
            else
                addEntry(1'b1, OP_ALU, '0, regAddr_t'(9 + k % 4), DATA_LFSR, '0);
        end
    endtask

    // drive one entry and predict its trace for the next cycle.
    task automatic issue(input stimulus_t s, input int index);
        word_t      data;
        word_t      word;
        logic [1:0] offset;
        int         wordIndex;
        case (s.mode)
            DATA_FIXED: data = s.fixedData;
            DATA_LFSR:  data = randomWord();
            DATA_NEG:   data = randomWord() | 32'h8080_8080;
            default:    data = randomWord() & 32'h7f7f_7f7f;
        endcase
        valid     = s.valid;
        op        = s.op;
        address   = s.address;
        storeData = data;
        aluResult = data;
        destReg   = s.destReg;
        pc        = 32'h0040_0000 + 32'(index * 4);
        offset    = s.address[1:0];
        wordIndex = int'((s.address >> 2) % MEM_WORDS);
        word      = refMem[wordIndex];
        expValid  = s.valid;
        expEnable = s.valid && (isLoad(s.op) || s.op == OP_ALU) && (s.destReg != 5'd0);
        expAddr   = s.destReg;
        expData   = isLoad(s.op) ? expectedLoad(s.op, word, offset) : data;
        expPc     = pc;
        if (s.valid && isStore(s.op))
        begin
            refMem[wordIndex] = mergeStore(s.op, word, data, offset);
        end
    endtask

    // called on a falling edge, before new inputs are driven.
    task automatic checkCycle();
        if (pendingWrite)
        begin
            refRegs[pendingAddr] = pendingData;
        end
        checkWord(rsData, refRegs[rsAddr], $sformatf("rsData of r%0d", rsAddr));
        checkWord(rtData, refRegs[rtAddr], $sformatf("rtData of r%0d", rtAddr));
        checkEnable(regWriteEnable, expEnable, "regWriteEnable");
        if (expValid)
        begin
            checkRegAddr(regWriteAddr, expAddr, "regWriteAddr");
            checkWord(pcWb, expPc, "pcWb");
        end
        if (expEnable)
        begin
            checkWord(regWriteData, expData, "regWriteData");
        end
        pendingWrite = expEnable;
        pendingAddr  = expAddr;
        pendingData  = expData;
    endtask

    initial
    begin
        stimulus_t bubble;
        stimulus_t inFlight;
        reset     = 1'b1;
        valid     = 1'b0;
        op        = OP_NONE;
        address   = '0;
        storeData = '0;
        aluResult = '0;
        destReg   = '0;
        pc        = '0;
        rsAddr    = '0;
        rtAddr    = '0;
        expValid  = 1'b0;
        expEnable = 1'b0;
        expAddr   = '0;
        expData   = '0;
        expPc     = '0;
        pendingWrite = 1'b0;
        pendingAddr  = '0;
        pendingData  = '0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            refMem[i] = '0;
        end
        for (int i = 0; i < 32; i++)
        begin
            refRegs[i] = '0;
        end
        bubble = '{1'b0, OP_NONE, '0, '0, DATA_FIXED, '0};
        inFlight = '{1'b1, OP_ALU, '0, 5'd20, DATA_FIXED, 32'hdead_beef};
        buildTable();
        cycleLimit = stimulusTable.size() + 64;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // two extra bubbles drain the pipeline.
        for (int i = 0; i < stimulusTable.size() + 2; i++)
        begin
            checkCycle();
            if (i < stimulusTable.size())
                issue(stimulusTable[i], i);
            else
                issue(bubble, i);
            rsAddr = pendingAddr;
            rtAddr = regAddr_t'(i);
            @(negedge clk);
        end

        // reset while one write-back is pending and a valid op is still issued.
        checkCycle();
        issue(inFlight, stimulusTable.size() + 2);
        @(negedge clk);
        checkCycle();
        reset = 1'b1;
        @(negedge clk);
        checkEnable(regWriteEnable, 1'b0, "regWriteEnable after reset");
        for (int j = 0; j < 16; j++)
        begin
            rsAddr = regAddr_t'(2 * j);
            rtAddr = regAddr_t'(2 * j + 1);
            @(negedge clk);
            checkWord(rsData, '0, $sformatf("rsData of r%0d after reset", rsAddr));
            checkWord(rtData, '0, $sformatf("rtData of r%0d after reset", rtAddr));
        end

        $display(">>> PASS");
        $finish;
    end

    initial
    begin
        cycleCount = 0;
        forever
        begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > cycleLimit)
            begin
                $display("timeout: the test did not finish within %0d cycles", cycleLimit);
                endInFailure();
            end
        end
    end

endmodule

`default_nettype wire

/* sources.f */
src/mipsPkg.sv
src/memStage.sv
src/memWbRegister.sv
src/writeBackStage.sv
src/registerFile.sv
src/memWbTop.sv
test/memWbTb_sva.sv
test/memWbTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = memWbTb
FILELIST = sources.f
OBJDIR   = obj_dir
BINARY   = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output.
run: compile
	@output="$$(./$(BINARY) 2>&1)"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJDIR)
